/* Makefile */
VERILATOR  = verilator
TOP        = tb_cpu
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
PASS_MSG   = Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu #(
	parameter int DATA_WIDTH = 32
) (
	input  cpu_ctrl_pkg::alu_op_e  op,
	input  logic [DATA_WIDTH-1:0]  a,
	input  logic [DATA_WIDTH-1:0]  b,
	output logic [DATA_WIDTH-1:0]  result,
	output logic                   zero
);
	import cpu_ctrl_pkg::*;

	localparam int SHAMT_WIDTH = $clog2(DATA_WIDTH);

	logic [SHAMT_WIDTH-1:0] shamt;

	assign shamt = b[SHAMT_WIDTH-1:0]; // Upper bits of b play no part in a shift.

	always_comb begin
		case (op)
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_SRL: result = a >> shamt;
			default: result = a + b;
		endcase
	end

	// Branches read this after ALU_SUB.
	assign zero = (result == '0);

endmodule

/* hdl/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

	// ----------------------------------------------------------------------
	// Select codes from the decoder to the selection stage
	// ----------------------------------------------------------------------

	// Source of the next program counter.
	typedef enum logic [1:0] {
		PC_PLUS4  = 2'b00,
		PC_BRANCH = 2'b01,
		PC_JUMP   = 2'b10,
		PC_HOLD   = 2'b11
	} pc_sel_e;

	typedef enum logic [1:0] {
		IMM5_ZE  = 2'b00,
		IMM15_SE = 2'b01,
		IMM15_ZE = 2'b10,
		IMM20_SE = 2'b11
	} imm_ext_e;

	// Second ALU operand. Codes 5 to 7 are not used.
	typedef enum logic [2:0] {
		SRC2_RB         = 3'b000,
		SRC2_IMM        = 3'b001,
		SRC2_WORD_OFS   = 3'b010,
		SRC2_RB_SHIFTED = 3'b011,
		SRC2_RT         = 3'b100
	} alu_src2_e;

	typedef enum logic [1:0] {
		WB_ALU     = 2'b00,
		WB_OPERAND = 2'b01, // The second ALU operand itself, for MOVI.
		WB_MEM     = 2'b10
	} wb_sel_e;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SRL = 3'd5
	} alu_op_e;

endpackage

/* hdl/cpu_isa_pkg.sv */
package cpu_isa_pkg;

	// ----------------------------------------------------------------------
	// Instruction word layout
	// ----------------------------------------------------------------------
	localparam int INSTR_WIDTH    = 32;
	localparam int OPCODE_LSB     = 26;
	localparam int OPCODE_WIDTH   = 6;
	localparam int RT_LSB         = 21;
	localparam int RA_LSB         = 16;
	localparam int RB_LSB         = 11;
	localparam int SV_LSB         = 8;  // Shift amount for ADD_SLLI.
	localparam int SV_WIDTH       = 2;
	localparam int IMM24_WIDTH    = 24; // Every immediate starts at bit 0.
	localparam int IMM20_WIDTH    = 20;
	localparam int IMM15_WIDTH    = 15;
	localparam int IMM14_WIDTH    = 14;
	localparam int IMM5_WIDTH     = 5;

	localparam int PC_WIDTH       = 10; // Byte address, steps by 4.
	localparam int REG_ADDR_WIDTH = 5;

	typedef enum logic [OPCODE_WIDTH-1:0] {
		OP_ADD      = 6'h00,
		OP_SUB      = 6'h01,
		OP_AND      = 6'h02,
		OP_OR       = 6'h03,
		OP_XOR      = 6'h04,
		OP_ADD_SLLI = 6'h05,
		OP_ADDI     = 6'h08,
		OP_ORI      = 6'h09,
		OP_SRLI     = 6'h0a,
		OP_MOVI     = 6'h0b,
		OP_LW       = 6'h10,
		OP_SW       = 6'h11,
		OP_BEQ      = 6'h18,
		OP_BNE      = 6'h19,
		OP_J        = 6'h1c,
		OP_HALT     = 6'h3f
	} opcode_e;

endpackage

/* hdl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
	parameter int DATA_WIDTH = 32,
	parameter int IMEM_DEPTH = 256,
	parameter int DMEM_DEPTH = 256
) (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   imem_we,
	input  logic [$clog2(IMEM_DEPTH)-1:0]          imem_addr,
	input  logic [cpu_isa_pkg::INSTR_WIDTH-1:0]    imem_wdata,
	input  logic [cpu_isa_pkg::REG_ADDR_WIDTH-1:0] dbg_addr,
	output logic [DATA_WIDTH-1:0]                  dbg_data,
	output logic                                   halted
);
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	localparam int IMEM_AW = $clog2(IMEM_DEPTH);
	localparam int DMEM_AW = $clog2(DMEM_DEPTH);

	logic [PC_WIDTH-1:0]    pc;
	logic [PC_WIDTH-1:0]    next_pc;
	logic [IMEM_AW-1:0]     imem_ram_addr;
	logic [INSTR_WIDTH-1:0] instr;
	opcode_e                opcode;
	pc_sel_e                pc_select;
	imm_ext_e               imm_extend_select;
	alu_src2_e              alu_src2_select;
	wb_sel_e                write_reg_select;
	alu_op_e                alu_op;
	logic                   reg_we;
	logic                   mem_we;
	logic                   dmem_we;
	logic                   halt;
	logic                   alu_zero;
	logic [DATA_WIDTH-1:0]  ra_data;
	logic [DATA_WIDTH-1:0]  rb_data;
	logic [DATA_WIDTH-1:0]  rt_data;
	logic [DATA_WIDTH-1:0]  alu_b;
	logic [DATA_WIDTH-1:0]  alu_result;
	logic [DATA_WIDTH-1:0]  mem_rdata;
	logic [DATA_WIDTH-1:0]  wb_data;

	// ----------------------------------------------------------------------
	// Program counter and halt flag
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			pc     <= '0;
			halted <= 1'b0;
		end else begin
			pc <= next_pc;
			if (halt)
				halted <= 1'b1; // Only reset clears it.
		end
	end

	// The load port borrows the fetch address while the program is written.
	assign imem_ram_addr = imem_we ? imem_addr : pc[IMEM_AW+1:2];

	word_ram #(.DATA_WIDTH(INSTR_WIDTH), .DEPTH(IMEM_DEPTH)) u_imem (
		.clk   (clk),
		.we    (imem_we),
		.addr  (imem_ram_addr),
		.wdata (imem_wdata),
		.rdata (instr)
	);

	assign opcode = opcode_e'(instr[OPCODE_LSB +: OPCODE_WIDTH]);

	decoder u_decoder (
		.opcode            (opcode),
		.alu_zero          (alu_zero),
		.pc_select         (pc_select),
		.imm_extend_select (imm_extend_select),
		.alu_src2_select   (alu_src2_select),
		.write_reg_select  (write_reg_select),
		.alu_op            (alu_op),
		.reg_we            (reg_we),
		.mem_we            (mem_we),
		.halt              (halt)
	);

	regfile #(.DATA_WIDTH(DATA_WIDTH)) u_regfile (
		.clk      (clk),
		.reset    (reset),
		.ra_addr  (instr[RA_LSB +: REG_ADDR_WIDTH]),
		.rb_addr  (instr[RB_LSB +: REG_ADDR_WIDTH]),
		.rt_addr  (instr[RT_LSB +: REG_ADDR_WIDTH]),
		.dbg_addr (dbg_addr),
		.we       (reg_we),
		.wdata    (wb_data),
		.ra_data  (ra_data),
		.rb_data  (rb_data),
		.rt_data  (rt_data),
		.dbg_data (dbg_data)
	);

	muxs #(.DATA_WIDTH(DATA_WIDTH)) u_muxs (
		.current_pc         (pc),
		.sub_op_sv          (instr[SV_LSB +: SV_WIDTH]),
		.reg_rb_data        (rb_data),
		.reg_rt_data        (rt_data),
		.mem_read_data      (mem_rdata),
		.alu_output         (alu_result),
		.imm_5bit           (instr[IMM5_WIDTH-1:0]),
		.imm_14bit          (instr[IMM14_WIDTH-1:0]),
		.imm_15bit          (instr[IMM15_WIDTH-1:0]),
		.imm_20bit          (instr[IMM20_WIDTH-1:0]),
		.imm_24bit          (instr[IMM24_WIDTH-1:0]),
		.pc_select          (pc_select),
		.imm_extend_select  (imm_extend_select),
		.alu_src2_select    (alu_src2_select),
		.write_reg_select   (write_reg_select),
		.next_pc            (next_pc),
		.output_imm_reg_mux (alu_b),
		.write_reg_data     (wb_data)
	);

	alu #(.DATA_WIDTH(DATA_WIDTH)) u_alu (
		.op     (alu_op),
		.a      (ra_data),
		.b      (alu_b),
		.result (alu_result),
		.zero   (alu_zero)
	);

	// No store may land while the program is being loaded.
	assign dmem_we = mem_we && !reset;

	word_ram #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DMEM_DEPTH)) u_dmem (
		.clk   (clk),
		.we    (dmem_we),
		.addr  (alu_result[DMEM_AW+1:2]), // Byte address to word index.
		.wdata (rt_data),
		.rdata (mem_rdata)
	);

endmodule

/* hdl/decoder.sv */
`timescale 1ns/1ps

module decoder (
	input  cpu_isa_pkg::opcode_e   opcode,
	input  logic                   alu_zero,
	output cpu_ctrl_pkg::pc_sel_e  pc_select,
	output cpu_ctrl_pkg::imm_ext_e imm_extend_select,
	output cpu_ctrl_pkg::alu_src2_e alu_src2_select,
	output cpu_ctrl_pkg::wb_sel_e  write_reg_select,
	output cpu_ctrl_pkg::alu_op_e  alu_op,
	output logic                   reg_we,
	output logic                   mem_we,
	output logic                   halt
);
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	always_comb begin
		// A plain register ALU operation is the starting point.
		pc_select         = PC_PLUS4;
		imm_extend_select = IMM15_SE;
		alu_src2_select   = SRC2_RB;
		write_reg_select  = WB_ALU;
		alu_op            = ALU_ADD;
		reg_we            = 1'b0;
		mem_we            = 1'b0;
		halt              = 1'b0;

		case (opcode)
			OP_ADD: reg_we = 1'b1;
			OP_SUB: begin
				alu_op = ALU_SUB;
				reg_we = 1'b1;
			end
			OP_AND: begin
				alu_op = ALU_AND;
				reg_we = 1'b1;
			end
			OP_OR: begin
				alu_op = ALU_OR;
				reg_we = 1'b1;
			end
			OP_XOR: begin
				alu_op = ALU_XOR;
				reg_we = 1'b1;
			end
			OP_ADD_SLLI: begin
				alu_src2_select = SRC2_RB_SHIFTED;
				reg_we          = 1'b1;
			end
			OP_ADDI: begin
				alu_src2_select = SRC2_IMM;
				reg_we          = 1'b1;
			end
			OP_ORI: begin
				imm_extend_select = IMM15_ZE;
				alu_src2_select   = SRC2_IMM;
				alu_op            = ALU_OR;
				reg_we            = 1'b1;
			end
			OP_SRLI: begin
				imm_extend_select = IMM5_ZE;
				alu_src2_select   = SRC2_IMM;
				alu_op            = ALU_SRL;
				reg_we            = 1'b1;
			end
			OP_MOVI: begin
				imm_extend_select = IMM20_SE;
				alu_src2_select   = SRC2_IMM;
				write_reg_select  = WB_OPERAND; // The ALU result is ignored.
				reg_we            = 1'b1;
			end
			OP_LW: begin
				alu_src2_select  = SRC2_WORD_OFS;
				write_reg_select = WB_MEM;
				reg_we           = 1'b1;
			end
			OP_SW: begin
				alu_src2_select = SRC2_WORD_OFS;
				mem_we          = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				// Subtracting rt from ra gives zero when they are equal.
				alu_src2_select = SRC2_RT;
				alu_op          = ALU_SUB;
				if (alu_zero == (opcode == OP_BEQ))
					pc_select = PC_BRANCH;
			end
			OP_J: pc_select = PC_JUMP;
			default: begin
				pc_select = PC_HOLD; // HALT, and anything not decoded.
				halt      = 1'b1;
			end
		endcase
	end

	always_comb begin
		assert (!(reg_we && mem_we))
			else $error("decoder: register and memory write in the same cycle");
	end

endmodule

/* hdl/muxs.sv */
`timescale 1ns/1ps

module muxs #(
	parameter int DATA_WIDTH = 32
) (
	input  logic [cpu_isa_pkg::PC_WIDTH-1:0]    current_pc,
	input  logic [cpu_isa_pkg::SV_WIDTH-1:0]    sub_op_sv,
	input  logic [DATA_WIDTH-1:0]               reg_rb_data,
	input  logic [DATA_WIDTH-1:0]               reg_rt_data,
	input  logic [DATA_WIDTH-1:0]               mem_read_data,
	input  logic [DATA_WIDTH-1:0]               alu_output,
	input  logic [cpu_isa_pkg::IMM5_WIDTH-1:0]  imm_5bit,
	input  logic [cpu_isa_pkg::IMM14_WIDTH-1:0] imm_14bit,
	input  logic [cpu_isa_pkg::IMM15_WIDTH-1:0] imm_15bit,
	input  logic [cpu_isa_pkg::IMM20_WIDTH-1:0] imm_20bit,
	input  logic [cpu_isa_pkg::IMM24_WIDTH-1:0] imm_24bit,
	input  cpu_ctrl_pkg::pc_sel_e               pc_select,
	input  cpu_ctrl_pkg::imm_ext_e              imm_extend_select,
	input  cpu_ctrl_pkg::alu_src2_e             alu_src2_select,
	input  cpu_ctrl_pkg::wb_sel_e               write_reg_select,
	output logic [cpu_isa_pkg::PC_WIDTH-1:0]    next_pc,
	output logic [DATA_WIDTH-1:0]               output_imm_reg_mux,
	output logic [DATA_WIDTH-1:0]               write_reg_data
);
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	logic [DATA_WIDTH-1:0] imm;
	logic [DATA_WIDTH-1:0] branch_ofs;
	logic [DATA_WIDTH-1:0] jump_ofs;

	// ----------------------------------------------------------------------
	// Next program counter
	// ----------------------------------------------------------------------
	// Offsets count halfwords, so they are doubled before the add.
	assign branch_ofs = {{(DATA_WIDTH-IMM14_WIDTH){imm_14bit[IMM14_WIDTH-1]}}, imm_14bit} << 1;
	assign jump_ofs   = {{(DATA_WIDTH-IMM24_WIDTH){imm_24bit[IMM24_WIDTH-1]}}, imm_24bit} << 1;

	always_comb begin
		case (pc_select)
			PC_PLUS4:  next_pc = current_pc + PC_WIDTH'(4);
			PC_BRANCH: next_pc = current_pc + branch_ofs[PC_WIDTH-1:0];
			PC_JUMP:   next_pc = current_pc + jump_ofs[PC_WIDTH-1:0];
			default:   next_pc = current_pc;
		endcase
	end

	// ----------------------------------------------------------------------
	// Immediate and second ALU operand
	// ----------------------------------------------------------------------
	always_comb begin
		case (imm_extend_select)
			IMM5_ZE:  imm = {{(DATA_WIDTH-IMM5_WIDTH){1'b0}}, imm_5bit};
			IMM15_SE: imm = {{(DATA_WIDTH-IMM15_WIDTH){imm_15bit[IMM15_WIDTH-1]}}, imm_15bit};
			IMM15_ZE: imm = {{(DATA_WIDTH-IMM15_WIDTH){1'b0}}, imm_15bit};
			default:  imm = {{(DATA_WIDTH-IMM20_WIDTH){imm_20bit[IMM20_WIDTH-1]}}, imm_20bit};
		endcase
	end

	always_comb begin
		case (alu_src2_select)
			SRC2_IMM:        output_imm_reg_mux = imm;
			SRC2_WORD_OFS:   output_imm_reg_mux = {{(DATA_WIDTH-IMM15_WIDTH-2){1'b0}}, imm_15bit, 2'b00};
			SRC2_RB_SHIFTED: output_imm_reg_mux = reg_rb_data << sub_op_sv;
			SRC2_RT:         output_imm_reg_mux = reg_rt_data;
			default:         output_imm_reg_mux = reg_rb_data;
		endcase
	end

	// Write-back value for rt.
	always_comb begin
		case (write_reg_select)
			WB_OPERAND: write_reg_data = output_imm_reg_mux;
			WB_MEM:     write_reg_data = mem_read_data;
			default:    write_reg_data = alu_output;
		endcase
	end

	always_comb begin
		assert (alu_src2_select inside {SRC2_RB, SRC2_IMM, SRC2_WORD_OFS, SRC2_RB_SHIFTED, SRC2_RT})
			else $error("muxs: undefined operand select %0d", alu_src2_select);
	end

endmodule

/* hdl/regfile.sv */
`timescale 1ns/1ps

module regfile #(
	parameter int DATA_WIDTH = 32
) (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic [cpu_isa_pkg::REG_ADDR_WIDTH-1:0] ra_addr,
	input  logic [cpu_isa_pkg::REG_ADDR_WIDTH-1:0] rb_addr,
	input  logic [cpu_isa_pkg::REG_ADDR_WIDTH-1:0] rt_addr,
	input  logic [cpu_isa_pkg::REG_ADDR_WIDTH-1:0] dbg_addr,
	input  logic                                   we,
	input  logic [DATA_WIDTH-1:0]                  wdata,
	output logic [DATA_WIDTH-1:0]                  ra_data,
	output logic [DATA_WIDTH-1:0]                  rb_data,
	output logic [DATA_WIDTH-1:0]                  rt_data,
	output logic [DATA_WIDTH-1:0]                  dbg_data
);
	import cpu_isa_pkg::*;

	localparam int NUM_REGS = 2 ** REG_ADDR_WIDTH;

	logic [DATA_WIDTH-1:0] regs [NUM_REGS];

	// Register 0 is writable like any other.
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[rt_addr] <= wdata;
		end
	end

	// All four reads are combinational.
	assign ra_data  = regs[ra_addr];
	assign rb_data  = regs[rb_addr];
	assign rt_data  = regs[rt_addr]; // Store data and branch compare.
	assign dbg_data = regs[dbg_addr];

endmodule

/* hdl/word_ram.sv */
`timescale 1ns/1ps

module word_ram #(
	parameter int DATA_WIDTH = 32,
	parameter int DEPTH      = 256
) (
	input  logic                     clk,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  logic [DATA_WIDTH-1:0]    wdata,
	output logic [DATA_WIDTH-1:0]    rdata
);

	logic [DATA_WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
	end

	assign rdata = mem[addr]; // Read is asynchronous.

	// A write must land inside the array.
	assert property (@(posedge clk) we |-> (int'(addr) < DEPTH))
		else $error("word_ram: write to word %0d past depth %0d", addr, DEPTH);

endmodule

/* tests/tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Register form. The shift amount only matters for ADD_SLLI.
function automatic logic [31:0] enc_reg(opcode_e op, int rt, int ra, int rb, int sv);
	logic [31:0] w;
	w = '0;
	w[OPCODE_LSB +: OPCODE_WIDTH] = op;
	w[RT_LSB +: REG_ADDR_WIDTH] = rt[REG_ADDR_WIDTH-1:0];
	w[RA_LSB +: REG_ADDR_WIDTH] = ra[REG_ADDR_WIDTH-1:0];
	w[RB_LSB +: REG_ADDR_WIDTH] = rb[REG_ADDR_WIDTH-1:0];
	w[SV_LSB +: SV_WIDTH] = sv[SV_WIDTH-1:0];
	return w;
endfunction

function automatic logic [31:0] enc_imm(opcode_e op, int rt, int ra, logic [14:0] imm);
	logic [31:0] w;
	w = enc_reg(op, rt, ra, 0, 0);
	w[IMM15_WIDTH-1:0] = imm;
	return w;
endfunction

function automatic logic [31:0] enc_movi(int rt, logic [19:0] imm);
	logic [31:0] w;
	w = enc_reg(OP_MOVI, rt, 0, 0, 0);
	w[IMM20_WIDTH-1:0] = imm;
	return w;
endfunction

// Offsets are given in bytes and stored as halfword counts.
function automatic logic [31:0] enc_branch(opcode_e op, int rt, int ra, int ofs_bytes);
	logic [31:0] w;
	int          imm;
	imm = ofs_bytes / 2;
	w = enc_reg(op, rt, ra, 0, 0);
	w[IMM14_WIDTH-1:0] = imm[IMM14_WIDTH-1:0];
	return w;
endfunction

function automatic logic [31:0] enc_jump(int ofs_bytes);
	logic [31:0] w;
	int          imm;
	imm = ofs_bytes / 2;
	w = enc_reg(OP_J, 0, 0, 0, 0);
	w[IMM24_WIDTH-1:0] = imm[IMM24_WIDTH-1:0];
	return w;
endfunction

function automatic logic [31:0] enc_halt();
	return enc_reg(OP_HALT, 0, 0, 0, 0);
endfunction

// Fibonacci LFSR with taps 32, 22, 2 and 1.
function automatic logic [31:0] lfsr_next(logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

/* tests/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;
	import cpu_isa_pkg::*;

	`include "tb_programs.svh"

	localparam int CLK_PERIOD = 40;
	localparam int TIMEOUT    = 200; // Cycles allowed for a program to reach HALT.

	logic        clk;
	logic        reset;
	logic        imem_we;
	logic [7:0]  imem_addr;
	logic [31:0] imem_wdata;
	logic [4:0]  dbg_addr;
	logic [31:0] dbg_data;
	logic        halted;
	logic [31:0] lfsr_state;
	logic [31:0] prog [$];
	int          checks;
	int          errors;

	cpu_top #(.DATA_WIDTH(32), .IMEM_DEPTH(256), .DMEM_DEPTH(256)) u_dut (
		.clk        (clk),
		.reset      (reset),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.dbg_addr   (dbg_addr),
		.dbg_data   (dbg_data),
		.halted     (halted)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// ------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------
	function automatic logic [31:0] random_word();
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < 32; i++) begin
			value = {value[30:0], lfsr_state[31]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return value;
	endfunction

	// Builds a full word as (upper 17 bits << 15) | lower 15 bits. Needs r0 at zero.
	task automatic load_const(input int rt, input logic [31:0] value);
		prog.push_back(enc_movi(rt, {3'b000, value[31:15]}));
		repeat (5) prog.push_back(enc_reg(OP_ADD_SLLI, rt, 0, rt, 3));
		prog.push_back(enc_imm(OP_ORI, rt, rt, value[14:0]));
	endtask

	task automatic run_program();
		int cycles;
		@(negedge clk);
		reset = 1'b1;
		foreach (prog[i]) begin
			@(negedge clk);
			imem_we    = 1'b1;
			imem_addr  = 8'(i);
			imem_wdata = prog[i];
		end
		@(negedge clk);
		imem_we = 1'b0;
		repeat (2) @(negedge clk);
		reset  = 1'b0;
		cycles = 0;
		while (!halted && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			errors++;
			$display("Timeout: the core did not halt within %0d cycles", TIMEOUT);
		end
		prog.delete();
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("[FAIL] %s = 0x%08h, expected 0x%08h", name, got, expected);
		end
	endtask

	task automatic read_reg(input int addr, output logic [31:0] value);
		@(negedge clk);
		dbg_addr = 5'(addr);
		#(CLK_PERIOD / 4);
		value = dbg_data;
	endtask

	task automatic check_reg(input int addr, input logic [31:0] expected, input string label);
		logic [31:0] got;
		read_reg(addr, got);
		check_value($sformatf("dbg_data (r%0d, %s)", addr, label), got, expected);
	endtask

	// ------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------
	task automatic test_immediates();
		logic [19:0] imm20;
		logic [14:0] imm_add;
		logic [14:0] imm_or;
		logic [31:0] r1;
		imm20   = 20'hfff3a;
		imm_add = 15'h7ff0;
		imm_or  = 15'h5a5a;
		r1      = {{12{imm20[19]}}, imm20};
		prog.push_back(enc_movi(1, imm20));
		prog.push_back(enc_imm(OP_ADDI, 2, 1, imm_add));
		prog.push_back(enc_imm(OP_ORI, 3, 0, imm_or));
		prog.push_back(enc_imm(OP_SRLI, 4, 1, 15'd9));
		prog.push_back(enc_halt());
		run_program();
		check_reg(1, r1, "MOVI");
		check_reg(2, r1 + {{17{imm_add[14]}}, imm_add}, "ADDI");
		check_reg(3, {17'b0, imm_or}, "ORI");
		check_reg(4, r1 >> 9, "SRLI");
	endtask

	task automatic test_reg_alu();
		logic [31:0] a;
		logic [31:0] b;
		a = random_word();
		b = random_word();
		load_const(1, a);
		load_const(2, b);
		prog.push_back(enc_reg(OP_ADD, 3, 1, 2, 0));
		prog.push_back(enc_reg(OP_SUB, 4, 1, 2, 0));
		prog.push_back(enc_reg(OP_AND, 5, 1, 2, 0));
		prog.push_back(enc_reg(OP_OR, 6, 1, 2, 0));
		prog.push_back(enc_reg(OP_XOR, 7, 1, 2, 0));
		for (int sv = 0; sv < 4; sv++)
			prog.push_back(enc_reg(OP_ADD_SLLI, 8 + sv, 1, 2, sv));
		prog.push_back(enc_halt());
		run_program();
		check_reg(1, a, "operand a");
		check_reg(2, b, "operand b");
		check_reg(3, a + b, "ADD");
		check_reg(4, a - b, "SUB");
		check_reg(5, a & b, "AND");
		check_reg(6, a | b, "OR");
		check_reg(7, a ^ b, "XOR");
		for (int sv = 0; sv < 4; sv++)
			check_reg(8 + sv, a + (b << sv), "ADD_SLLI");
	endtask

	task automatic test_load_store();
		logic [31:0] v1;
		logic [31:0] v2;
		v1 = random_word();
		v2 = random_word();
		load_const(2, v1);
		load_const(3, v2);
		prog.push_back(enc_movi(1, 20'd40));
		prog.push_back(enc_imm(OP_SW, 2, 1, 15'd3)); // Byte 52, word 13.
		prog.push_back(enc_imm(OP_SW, 3, 1, 15'd5));
		prog.push_back(enc_imm(OP_LW, 4, 1, 15'd3));
		prog.push_back(enc_imm(OP_LW, 5, 1, 15'd5));
		prog.push_back(enc_imm(OP_ADDI, 7, 1, 15'd8));
		prog.push_back(enc_imm(OP_LW, 6, 7, 15'd1)); // Same word 13 from another base.
		prog.push_back(enc_halt());
		run_program();
		check_reg(4, v1, "LW offset 3");
		check_reg(5, v2, "LW offset 5");
		check_reg(6, v1, "LW base 48 offset 1");
	endtask

	task automatic test_branches();
		prog.push_back(enc_movi(1, 20'd7));
		prog.push_back(enc_movi(2, 20'd7));
		prog.push_back(enc_branch(OP_BEQ, 1, 2, 8)); // Word 2, taken to word 4.
		prog.push_back(enc_movi(10, 20'd1));
		prog.push_back(enc_branch(OP_BNE, 1, 2, -16)); // Backward, not taken.
		prog.push_back(enc_movi(11, 20'd1));
		prog.push_back(enc_branch(OP_BEQ, 1, 2, 12)); // Word 6, taken to word 9.
		prog.push_back(enc_movi(12, 20'd1));
		prog.push_back(enc_halt());
		prog.push_back(enc_movi(13, 20'd1));
		prog.push_back(enc_branch(OP_BEQ, 1, 2, -8)); // Word 10, back to the HALT at 8.
		prog.push_back(enc_movi(14, 20'd1));
		prog.push_back(enc_halt());
		run_program();
		check_reg(10, 32'd0, "BEQ forward skip");
		check_reg(11, 32'd1, "BNE not taken");
		check_reg(12, 32'd0, "BEQ second skip");
		check_reg(13, 32'd1, "BEQ target");
		check_reg(14, 32'd0, "BEQ backward skip");
	endtask

	task automatic test_jump();
		prog.push_back(enc_movi(1, 20'd5));
		prog.push_back(enc_jump(16)); // Word 1 to word 5.
		prog.push_back(enc_movi(2, 20'd1));
		prog.push_back(enc_movi(3, 20'd1));
		prog.push_back(enc_halt());
		prog.push_back(enc_movi(4, 20'd1));
		prog.push_back(enc_halt());
		run_program();
		check_reg(1, 32'd5, "before J");
		check_reg(2, 32'd0, "skipped by J");
		check_reg(3, 32'd0, "skipped by J");
		check_reg(4, 32'd1, "J target");
	endtask

	task automatic test_halt();
		logic [31:0] value;
		prog.push_back(enc_movi(5, 20'h12345));
		prog.push_back(enc_imm(OP_ADDI, 6, 5, 15'd1));
		prog.push_back(enc_halt());
		prog.push_back(enc_imm(OP_ADDI, 5, 5, 15'd1)); // Reached only if the PC moves past HALT.
		run_program();
		for (int i = 0; i < 10; i++) begin
			read_reg(5 + (i % 2), value);
			check_value("halted", {31'b0, halted}, 32'd1);
			check_value("dbg_data (frozen)", value, 32'h0001_2345 + 32'(i % 2));
		end
		@(negedge clk);
		reset = 1'b1;
		repeat (2) @(negedge clk);
		check_value("halted", {31'b0, halted}, 32'd0);
		check_reg(5, 32'd0, "after reset");
		check_reg(6, 32'd0, "after reset");
	endtask

	// ------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------
	initial begin
		reset      = 1'b1;
		imem_we    = 1'b0;
		imem_addr  = '0;
		imem_wdata = '0;
		dbg_addr   = '0;
		lfsr_state = 32'he98d_f25c;
		checks     = 0;
		errors     = 0;
		repeat (2) @(negedge clk);

		test_immediates();
		test_reg_alu();
		test_load_store();
		test_branches();
		test_jump();
		test_halt();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+tests
hdl/cpu_isa_pkg.sv
hdl/cpu_ctrl_pkg.sv
hdl/decoder.sv
hdl/muxs.sv
hdl/regfile.sv
hdl/alu.sv
hdl/word_ram.sv
hdl/cpu_top.sv
tests/tb_cpu.sv
